/* sim.f */
nvic_reg_pkg.sv
nvic_irq_pkg.sv
nvic_ctrl_decode.sv
nvic_irq_line.sv
nvic_prio_arbiter.sv
nvic_top.sv
nvic_asserts.sv
tb_nvic.sv

/* tb_nvic.sv */
`timescale 1ns/1ps

module tb_nvic;

   import nvic_reg_pkg::*;
   import nvic_irq_pkg::*;

   localparam int          NUM_IRQ     = 8;
   localparam int          NUM_W       = $clog2(NUM_IRQ);
   localparam int          TIMEOUT_CYC = 2000;               // tests need about 600
   localparam logic [31:0] LINE_MASK   = 32'((64'd1 << NUM_IRQ) - 1);
   localparam logic [7:0]  BYTE_KEEP   = 8'hFF << PRIO_LSB;  // implemented prio bits

   logic               hclk = 1'b0;
   logic               hreset_n;
   logic [NUM_IRQ-1:0] irq_i;
   logic               ppb_write_i;
   logic               ppb_read_i;
   ppb_addr_t          ppb_addr_i;
   logic [31:0]        ppb_wdata_i;
   logic [31:0]        ppb_rdata_o;
   logic               int_taken_i;
   logic               int_return_i;
   logic [NUM_W-1:0]   ret_num_i;
   logic               int_pend_o;
   logic [NUM_W-1:0]   int_pend_num_o;

   int                 seed      = 32'h35ed_6837;
   int                 cycle_cnt = 0;
   prio_t              prio_tab [NUM_IRQ];                   // programmed priorities
   logic [31:0]        en_exp;                               // expected enable set
   logic [31:0]        word;
   logic [NUM_IRQ-1:0] pend_mask;

   nvic_top #(.NUM_IRQ(NUM_IRQ)) DUT (.*);

   always #10 hclk = ~hclk;                                  // 20 ns period

   always @(posedge hclk) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= TIMEOUT_CYC) begin
         stop_run("timeout, the tests did not finish within the cycle limit");
      end
   end

   // --------------------------------------------------
   // register port and core side tasks
   // --------------------------------------------------

   task automatic stop_run(input string why);
      $display("%s", why);
      $display("Finished with errors");
      $fatal(1);
   endtask

   task automatic check_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
      assert (exp === act) else begin
         stop_run($sformatf("Mismatch in %s: expected %0h, actual %0h", name, exp, act));
      end
   endtask

   task automatic write_reg(input ppb_addr_t addr, input logic [31:0] data);
      @(posedge hclk);
      ppb_write_i <= 1'b1;
      ppb_addr_i  <= addr;
      ppb_wdata_i <= data;
      @(posedge hclk);
      ppb_write_i <= 1'b0;                                   // sampled on this edge
   endtask

   task automatic read_check(input string name, input ppb_addr_t addr, input logic [31:0] exp);
      @(posedge hclk);
      ppb_read_i <= 1'b1;
      ppb_addr_i <= addr;
      @(posedge hclk);
      ppb_read_i <= 1'b0;
      @(negedge hclk);                                       // rdata settled by now
      check_eq(name, exp, ppb_rdata_o);
   endtask

   // waits for int_pend_o, then compares the presented number
   task automatic expect_pend(input string name, input int num);
      int n;
      n = 0;
      @(negedge hclk);
      while (!int_pend_o) begin
         n++;
         if (n > 20) begin
            stop_run($sformatf("%s: int_pend_o never went high", name));
         end
         @(negedge hclk);
      end
      check_eq(name, num, int_pend_num_o);
   endtask

   // first edge still shows state from before the last write
   task automatic expect_quiet(input string name, input int cycles);
      @(posedge hclk);
      repeat (cycles) begin
         @(negedge hclk);
         check_eq(name, 0, int_pend_o);
      end
   endtask

   task automatic core_take();
      @(posedge hclk);
      int_taken_i <= 1'b1;
      @(posedge hclk);
      int_taken_i <= 1'b0;
   endtask

   task automatic core_return(input int num);
      @(posedge hclk);
      int_return_i <= 1'b1;
      ret_num_i    <= NUM_W'(num);
      @(posedge hclk);
      int_return_i <= 1'b0;
   endtask

   task automatic write_prio_table();
      for (int n = 0; n < NUM_IRQ / 4; n++) begin
         word = '0;
         for (int k = 0; k < 4; k++) begin
            word[8 * k + PRIO_LSB +: PRIO_BITS] = prio_tab[4 * n + k];
         end
         write_reg(ppb_addr_t'(IPR_BASE_OFS + n), word);
      end
   endtask

   // most urgent level first, lowest index within a level
   function automatic int winner(input logic [NUM_IRQ-1:0] pend);
      for (int p = 0; p < 2 ** PRIO_BITS; p++) begin
         for (int i = 0; i < NUM_IRQ; i++) begin
            if (pend[i] && (prio_tab[i] == p)) begin
               return i;
            end
         end
      end
      return -1;
   endfunction

   task automatic arb_round(input string name);
      write_reg(ISPR_OFS, 32'(pend_mask));
      expect_pend(name, winner(pend_mask));
      write_reg(ICPR_OFS, LINE_MASK);                        // back to idle
      expect_quiet(name, 1);
   endtask

   // --------------------------------------------------
   // stimulus
   // --------------------------------------------------

   initial begin
      hreset_n     = 1'b0;
      irq_i        = '0;
      ppb_write_i  = 1'b0;
      ppb_read_i   = 1'b0;
      ppb_addr_i   = '0;
      ppb_wdata_i  = '0;
      int_taken_i  = 1'b0;
      int_return_i = 1'b0;
      ret_num_i    = '0;
      repeat (2) @(posedge hclk);
      hreset_n <= 1'b1;

      @(negedge hclk);
      check_eq("reset_pend", 0, int_pend_o);
      read_check("reset_iser", ISER_OFS, 0);
      read_check("reset_ispr", ISPR_OFS, 0);
      for (int n = 0; n < 8; n++) begin
         read_check("reset_ipr", ppb_addr_t'(IPR_BASE_OFS + n), 0);
      end

      word = $random(seed);                                  // enable set then clear
      write_reg(ISER_OFS, word);
      en_exp = word & LINE_MASK;
      word = $random(seed);
      write_reg(ICER_OFS, word);
      en_exp = en_exp & ~word;
      read_check("iser_readback", ISER_OFS, en_exp);
      read_check("icer_readback", ICER_OFS, en_exp);
      for (int n = 0; n < NUM_IRQ / 4; n++) begin
         word = $random(seed);
         write_reg(ppb_addr_t'(IPR_BASE_OFS + n), word);
         read_check("ipr_readback", ppb_addr_t'(IPR_BASE_OFS + n), word & {4{BYTE_KEEP}});
      end
      for (int a = 4; a < 16; a++) begin
         if (a < IPR_BASE_OFS || a >= IPR_BASE_OFS + NUM_IRQ / 4) begin
            write_reg(ppb_addr_t'(a), $random(seed));
            read_check("unmapped_read", ppb_addr_t'(a), 0);
         end
      end
      read_check("unmapped_write", ISER_OFS, en_exp);
      write_reg(ICER_OFS, LINE_MASK);

      write_reg(ISER_OFS, 32'h1 << 2);                       // level irq on line 2
      @(posedge hclk);
      irq_i[2] <= 1'b1;
      expect_pend("irq_pend", 2);
      @(posedge hclk);
      irq_i[2] <= 1'b0;
      write_reg(ICPR_OFS, 32'h1 << 2);
      expect_quiet("icpr_clear", 3);
      write_reg(ISPR_OFS, 32'h1 << 5);                       // line 5 stays disabled
      read_check("ispr_disabled", ISPR_OFS, 32'h1 << 5);
      expect_quiet("disabled_quiet", 4);
      write_reg(ICPR_OFS, 32'h1 << 5);
      read_check("icpr_disabled", ISPR_OFS, 0);

      write_reg(ISER_OFS, LINE_MASK);
      foreach (prio_tab[i]) begin
         prio_tab[i] = 2'd1;
      end
      write_prio_table();
      pend_mask = NUM_IRQ'(8'h68);                           // lines 3, 5 and 6 tie
      arb_round("arb_tie");
      repeat (12) begin
         foreach (prio_tab[i]) begin
            prio_tab[i] = prio_t'($random(seed));
         end
         write_prio_table();
         pend_mask = NUM_IRQ'($random(seed));
         if (pend_mask == '0) begin
            pend_mask = NUM_IRQ'(1);
         end
         arb_round("arb_random");
      end

      foreach (prio_tab[i]) begin
         prio_tab[i] = 2'd3;
      end
      prio_tab[1] = 2'd2;
      prio_tab[4] = 2'd2;
      prio_tab[6] = 2'd1;
      write_prio_table();
      write_reg(ISPR_OFS, 32'h1 << 1);
      expect_pend("take_first", 1);
      core_take();
      @(negedge hclk);
      check_eq("take_gap", 0, int_pend_o);
      write_reg(ISPR_OFS, 32'h11);                           // lines 4 and 0 not more urgent
      expect_quiet("blocked", 4);
      write_reg(ISPR_OFS, 32'h1 << 6);
      expect_pend("preempt", 6);
      core_take();
      core_return(6);
      expect_quiet("still_blocked", 4);                      // line 1 still active
      core_return(1);
      expect_pend("unblocked", 4);
      core_take();
      core_return(4);
      expect_pend("unblocked_last", 0);
      core_take();
      core_return(0);
      expect_quiet("all_done", 2);

      @(posedge hclk);
      $display("Finished with no errors");
      $finish;
   end

endmodule

/* nvic_asserts.sv */
`timescale 1ns/1ps

module nvic_asserts #(
   parameter  int NUM_IRQ = 8,
   localparam int NUM_W   = $clog2(NUM_IRQ)
) (
   input logic             hclk,
   input logic             hreset_n,
   input logic             int_taken_i,
   input logic             int_pend_o,
   input logic [NUM_W-1:0] int_pend_num_o
);

   // presented number names a real line
   a_num_range: assert property (@(posedge hclk) disable iff (!hreset_n)
      int_pend_o |-> (!$isunknown(int_pend_num_o) && (int_pend_num_o < NUM_IRQ)))
      else $error("int_pend_num_o unknown or out of range while int_pend_o is high");

   // accepted take blanks the request for one cycle
   a_take_gap: assert property (@(posedge hclk) disable iff (!hreset_n)
      (int_taken_i && int_pend_o) |=> !int_pend_o)
      else $error("int_pend_o high in the cycle after an accepted take");

   // nothing presented right after reset release
   a_reset_quiet: assert property (@(posedge hclk)
      $rose(hreset_n) |-> !int_pend_o ##1 !int_pend_o)
      else $error("int_pend_o high within two cycles of reset release");

endmodule

bind nvic_top nvic_asserts #(.NUM_IRQ(NUM_IRQ)) u_asserts (
   .hclk           (hclk),
   .hreset_n       (hreset_n),
   .int_taken_i    (int_taken_i),
   .int_pend_o     (int_pend_o),
   .int_pend_num_o (int_pend_num_o)
);

/* nvic_top.sv */
`timescale 1ns/1ps

module nvic_top #(
   parameter  int NUM_IRQ = 8,
   localparam int NUM_W   = $clog2(NUM_IRQ)
) (
   input  logic                     hclk,
   input  logic                     hreset_n,
   input  logic [NUM_IRQ-1:0]       irq_i,          // level interrupts
   input  logic                     ppb_write_i,
   input  logic                     ppb_read_i,
   input  nvic_reg_pkg::ppb_addr_t  ppb_addr_i,
   input  nvic_reg_pkg::ppb_wdata_u ppb_wdata_i,
   output logic [31:0]              ppb_rdata_o,
   input  logic                     int_taken_i,    // core entered handler
   input  logic                     int_return_i,   // core left handler
   input  logic [NUM_W-1:0]         ret_num_i,
   output logic                     int_pend_o,
   output logic [NUM_W-1:0]         int_pend_num_o
);

   import nvic_irq_pkg::*;

   irq_ctrl_t  [NUM_IRQ-1:0] line_ctrl;             // decoder to cells
   irq_state_t [NUM_IRQ-1:0] line_state;            // cells to decoder and arbiter
   logic       [NUM_IRQ-1:0] take_onehot;           // arbiter to cells

   // --------------------------------------------------
   // register decode
   // --------------------------------------------------

   nvic_ctrl_decode #(.NUM_IRQ(NUM_IRQ)) u_decode (
      .hclk         (hclk),
      .hreset_n     (hreset_n),
      .ppb_write_i  (ppb_write_i),
      .ppb_read_i   (ppb_read_i),
      .ppb_addr_i   (ppb_addr_i),
      .ppb_wdata_i  (ppb_wdata_i),
      .int_return_i (int_return_i),
      .ret_num_i    (ret_num_i),
      .line_state_i (line_state),
      .line_ctrl_o  (line_ctrl),
      .ppb_rdata_o  (ppb_rdata_o)
   );

   // one cell per line
   for (genvar i = 0; i < NUM_IRQ; i++) begin : g_line
      nvic_irq_line u_line (
         .hclk     (hclk),
         .hreset_n (hreset_n),
         .irq_i    (irq_i[i]),
         .ctrl_i   (line_ctrl[i]),
         .take_i   (take_onehot[i]),
         .state_o  (line_state[i])
      );
   end

   // --------------------------------------------------
   // arbitration
   // --------------------------------------------------

   nvic_prio_arbiter #(.NUM_IRQ(NUM_IRQ)) u_arbiter (
      .hclk           (hclk),
      .hreset_n       (hreset_n),
      .line_state_i   (line_state),
      .int_taken_i    (int_taken_i),
      .take_onehot_o  (take_onehot),
      .int_pend_o     (int_pend_o),
      .int_pend_num_o (int_pend_num_o)
   );

endmodule

/* nvic_prio_arbiter.sv */
`timescale 1ns/1ps

module nvic_prio_arbiter #(
   parameter  int NUM_IRQ = 8,
   localparam int NUM_W   = $clog2(NUM_IRQ)
) (
   input  logic                                   hclk,
   input  logic                                   hreset_n,
   input  nvic_irq_pkg::irq_state_t [NUM_IRQ-1:0] line_state_i,
   input  logic                                   int_taken_i,    // core takes pending
   output logic [NUM_IRQ-1:0]                     take_onehot_o,  // back to line cells
   output logic                                   int_pend_o,
   output logic [NUM_W-1:0]                       int_pend_num_o
);

   import nvic_irq_pkg::*;

   // one above every prio so thread level is preempted by anything
   localparam logic [PRIO_BITS:0] PRIO_IDLE = {1'b1, {PRIO_BITS{1'b0}}};

   logic [PRIO_BITS:0] exec_prio;                  // current execution priority
   logic [NUM_IRQ-1:0] eligible;                   // line may preempt
   logic               best_vld;                   // some line eligible
   prio_t              best_prio;                  // winning prio so far
   logic [NUM_W-1:0]   best_num;                   // winning line so far
   logic               take_acc;                   // take accepted this cycle

   // --------------------------------------------------
   // execution priority from active lines
   // --------------------------------------------------

   always_comb begin
      exec_prio = PRIO_IDLE;
      for (int i = 0; i < NUM_IRQ; i++) begin
         if (line_state_i[i].active && ({1'b0, line_state_i[i].prio} < exec_prio)) begin
            exec_prio = {1'b0, line_state_i[i].prio};
         end
      end
   end

   for (genvar i = 0; i < NUM_IRQ; i++) begin : g_elig
      assign eligible[i] = line_state_i[i].enabled && line_state_i[i].pending &&
                           !line_state_i[i].active &&
                           ({1'b0, line_state_i[i].prio} < exec_prio); // strict preempt
   end

   // --------------------------------------------------
   // winner scan
   // --------------------------------------------------

   always_comb begin
      best_vld  = 1'b0;
      best_prio = '0;
      best_num  = '0;
      for (int i = 0; i < NUM_IRQ; i++) begin
         // strict compare keeps the lower index on a tie
         if (eligible[i] && (!best_vld || (line_state_i[i].prio < best_prio))) begin
            best_vld  = 1'b1;
            best_prio = line_state_i[i].prio;
            best_num  = NUM_W'(i);
         end
      end
   end

   // --------------------------------------------------
   // core side
   // --------------------------------------------------

   assign take_acc = int_taken_i && int_pend_o;    // ignored while nothing pends

   for (genvar i = 0; i < NUM_IRQ; i++) begin : g_take
      assign take_onehot_o[i] = take_acc && (int_pend_num_o == NUM_W'(i));
   end

   always_ff @(posedge hclk or negedge hreset_n) begin
      if (!hreset_n) begin
         int_pend_o     <= 1'b0;
         int_pend_num_o <= '0;
      end else begin
         int_pend_o     <= best_vld && !take_acc;  // scan still sees taken line
         int_pend_num_o <= best_num;
      end
   end

endmodule

/* nvic_irq_line.sv */
`timescale 1ns/1ps

module nvic_irq_line (
   input  logic                     hclk,
   input  logic                     hreset_n,
   input  logic                     irq_i,          // raw level from source
   input  nvic_irq_pkg::irq_ctrl_t  ctrl_i,         // strobes from decoder
   input  logic                     take_i,         // line taken by core
   output nvic_irq_pkg::irq_state_t state_o
);

   import nvic_irq_pkg::*;

   irq_state_t state_q;                             // line flops
   logic       pend_set;                            // any source setting pending

   // level input latches only while the handler is not running
   assign pend_set = (irq_i && !state_q.active) || ctrl_i.set_pend;

   // --------------------------------------------------
   // enable and priority
   // --------------------------------------------------

   always_ff @(posedge hclk or negedge hreset_n) begin
      if (!hreset_n) begin
         state_q.enabled <= 1'b0;
         state_q.prio    <= '0;
      end else begin
         if (ctrl_i.set_en) begin
            state_q.enabled <= 1'b1;
         end else if (ctrl_i.clr_en) begin
            state_q.enabled <= 1'b0;
         end
         if (ctrl_i.prio_we) begin
            state_q.prio <= ctrl_i.prio_wdata;      // IPR byte write
         end
      end
   end

   // --------------------------------------------------
   // pending and active
   // --------------------------------------------------

   always_ff @(posedge hclk or negedge hreset_n) begin
      if (!hreset_n) begin
         state_q.pending <= 1'b0;
         state_q.active  <= 1'b0;
      end else begin
         if (take_i) begin
            state_q.pending <= 1'b0;                // take consumes pending
         end else if (pend_set) begin
            state_q.pending <= 1'b1;                // set beats ICPR
         end else if (ctrl_i.clr_pend) begin
            state_q.pending <= 1'b0;
         end

         if (take_i) begin
            state_q.active <= 1'b1;                 // handler entered
         end else if (ctrl_i.clr_active) begin
            state_q.active <= 1'b0;                 // handler returned
         end
      end
   end

   assign state_o = state_q;

endmodule

/* nvic_ctrl_decode.sv */
`timescale 1ns/1ps

module nvic_ctrl_decode #(
   parameter  int NUM_IRQ = 8,
   localparam int NUM_W   = $clog2(NUM_IRQ)
) (
   input  logic                                   hclk,
   input  logic                                   hreset_n,
   input  logic                                   ppb_write_i,   // write strobe
   input  logic                                   ppb_read_i,    // read strobe
   input  nvic_reg_pkg::ppb_addr_t                ppb_addr_i,
   input  nvic_reg_pkg::ppb_wdata_u               ppb_wdata_i,
   input  logic                                   int_return_i,  // core return pulse
   input  logic [NUM_W-1:0]                       ret_num_i,     // returning line
   input  nvic_irq_pkg::irq_state_t [NUM_IRQ-1:0] line_state_i,
   output nvic_irq_pkg::irq_ctrl_t  [NUM_IRQ-1:0] line_ctrl_o,
   output logic [31:0]                            ppb_rdata_o
);

   import nvic_reg_pkg::*;
   import nvic_irq_pkg::*;

   logic        wr_iser;                                         // write hits ISER
   logic        wr_icer;                                         // write hits ICER
   logic        wr_ispr;                                         // write hits ISPR
   logic        wr_icpr;                                         // write hits ICPR
   logic [31:0] rd_word;                                         // read data before flop

   // --------------------------------------------------
   // write decode
   // --------------------------------------------------

   assign wr_iser = ppb_write_i && (ppb_addr_i == ISER_OFS);
   assign wr_icer = ppb_write_i && (ppb_addr_i == ICER_OFS);
   assign wr_ispr = ppb_write_i && (ppb_addr_i == ISPR_OFS);
   assign wr_icpr = ppb_write_i && (ppb_addr_i == ICPR_OFS);

   for (genvar i = 0; i < NUM_IRQ; i++) begin : g_ctrl
      // priority word and byte lane that hold this line
      localparam ppb_addr_t IPR_OFS  = ppb_addr_t'(IPR_BASE_OFS + i / 4);
      localparam int        IPR_BYTE = i % 4;

      // mask view of the write word
      assign line_ctrl_o[i].set_en   = wr_iser && ppb_wdata_i.mask[i];
      assign line_ctrl_o[i].clr_en   = wr_icer && ppb_wdata_i.mask[i];
      assign line_ctrl_o[i].set_pend = wr_ispr && ppb_wdata_i.mask[i];
      assign line_ctrl_o[i].clr_pend = wr_icpr && ppb_wdata_i.mask[i];

      // byte view of the same word
      assign line_ctrl_o[i].prio_we    = ppb_write_i && (ppb_addr_i == IPR_OFS);
      assign line_ctrl_o[i].prio_wdata =
         ppb_wdata_i.prio_byte[IPR_BYTE][PRIO_LSB +: PRIO_BITS]; // top bits only

      // core return drops active on the named line
      assign line_ctrl_o[i].clr_active = int_return_i && (ret_num_i == NUM_W'(i));
   end

   // --------------------------------------------------
   // read mux
   // --------------------------------------------------

   always_comb begin
      rd_word = '0;                                              // unmapped reads zero
      for (int i = 0; i < NUM_IRQ; i++) begin
         case (ppb_addr_i)
            ISER_OFS, ICER_OFS: begin
               rd_word[i] = line_state_i[i].enabled;             // both show enables
            end
            ISPR_OFS, ICPR_OFS: begin
               rd_word[i] = line_state_i[i].pending;             // both show pendings
            end
            default: begin
               if (ppb_addr_i == ppb_addr_t'(IPR_BASE_OFS + i / 4)) begin
                  rd_word[8 * (i % 4) + PRIO_LSB +: PRIO_BITS] = line_state_i[i].prio;
               end
            end
         endcase
      end
   end

   // read data held until the next read
   always_ff @(posedge hclk or negedge hreset_n) begin
      if (!hreset_n) begin
         ppb_rdata_o <= '0;
      end else if (ppb_read_i) begin
         ppb_rdata_o <= rd_word;                                 // valid one cycle later
      end
   end

endmodule

/* nvic_irq_pkg.sv */
package nvic_irq_pkg;

   // --------------------------------------------------
   // priority and per-line types
   // --------------------------------------------------

   localparam int PRIO_BITS = 2;                      // implemented prio width

   typedef logic [PRIO_BITS-1:0] prio_t;              // lower value more urgent

   // single-cycle strobes into one line cell
   typedef struct packed {
      logic  set_en;                                  // ISER bit
      logic  clr_en;                                  // ICER bit
      logic  set_pend;                                // ISPR bit
      logic  clr_pend;                                // ICPR bit
      logic  clr_active;                              // core return names line
      logic  prio_we;                                 // IPR byte written
      prio_t prio_wdata;                              // new priority
   } irq_ctrl_t;

   // state reported by one line cell
   typedef struct packed {
      logic  enabled;
      logic  pending;
      logic  active;                                  // handler running or stacked
      prio_t prio;
   } irq_state_t;

endpackage

/* nvic_reg_pkg.sv */
package nvic_reg_pkg;

   // --------------------------------------------------
   // register map of the controller window
   // --------------------------------------------------

   typedef logic [3:0] ppb_addr_t;                    // word offset in window

   localparam ppb_addr_t ISER_OFS     = 4'd0;         // set enable
   localparam ppb_addr_t ICER_OFS     = 4'd1;         // clear enable
   localparam ppb_addr_t ISPR_OFS     = 4'd2;         // set pending
   localparam ppb_addr_t ICPR_OFS     = 4'd3;         // clear pending
   localparam ppb_addr_t IPR_BASE_OFS = 4'd8;         // first priority word

   // implemented priority bits sit at the top of each byte
   localparam int PRIO_LSB = 6;

   // --------------------------------------------------
   // write word seen two ways
   // --------------------------------------------------

   // set and clear registers use the mask view
   // priority registers use the byte view with four lines per word
   typedef union packed {
      logic [31:0]     mask;                          // one bit per line
      logic [3:0][7:0] prio_byte;                     // byte k is line 4n+k
   } ppb_wdata_u;

endpackage
